// ==== hdl/mipsIsaPkg.sv ====
package mipsIsaPkg;

	////////////////////
	// Primary opcodes, instr[31:26]
	////////////////////
	localparam logic [5:0] opLB  = 6'h20;
	localparam logic [5:0] opLH  = 6'h21;
	localparam logic [5:0] opLW  = 6'h23;
	localparam logic [5:0] opLBU = 6'h24;
	localparam logic [5:0] opLHU = 6'h25;
	localparam logic [5:0] opSB  = 6'h28;
	localparam logic [5:0] opSH  = 6'h29;
	localparam logic [5:0] opSW  = 6'h2B;

	////////////////////
	// Exception codes
	////////////////////
	typedef logic [4:0] excCode_t;

	localparam excCode_t excNone = 5'd0;
	// Address error on load or fetch
	localparam excCode_t excAdEL = 5'd4;
	// Address error on store
	localparam excCode_t excAdES = 5'd5;

	////////////////////
	// Access kind
	////////////////////
	// halfAlign and wordAlign are both low for byte accesses
	typedef struct packed {
		logic isLoad;
		logic isStore;
		logic halfAlign;
		logic wordAlign;
		logic loadUnsigned;
	} accessKind_t;

endpackage

// ==== hdl/memMapPkg.sv ====
package memMapPkg;

	////////////////////
	// Address map
	////////////////////
	localparam logic [31:0] dmMin = 32'h0000_0000;
	localparam logic [31:0] dmMax = 32'h0000_2FFF;

	localparam int maxDev = 6;

	// Device k sits at 0x7F00 + 16k, three words each
	localparam logic [0:maxDev-1][31:0] devMin = {
		32'h0000_7F00, 32'h0000_7F10, 32'h0000_7F20,
		32'h0000_7F30, 32'h0000_7F40, 32'h0000_7F50
	};
	localparam logic [0:maxDev-1][31:0] devMax = {
		32'h0000_7F0B, 32'h0000_7F1B, 32'h0000_7F2B,
		32'h0000_7F3B, 32'h0000_7F4B, 32'h0000_7F5B
	};

	// Read-only status word in device 0
	localparam logic [31:0] noWriteAddr = 32'h0000_7F08;

	////////////////////
	// Stage payloads
	////////////////////
	typedef struct packed {
		logic                 valid;
		logic [31:0]          instr;
		logic [31:0]          addr;
		logic [31:0]          storeData;
		logic                 preExcGet;
		mipsIsaPkg::excCode_t preExcCode;
	} memReq_t;

	typedef struct packed {
		logic                 valid;
		logic [31:0]          loadData;
		logic                 excGet;
		mipsIsaPkg::excCode_t excCode;
	} memResult_t;

endpackage

// ==== hdl/pipeStageReg.sv ====
`timescale 1ns/1ps

// Generic pipeline register, cleared to all zeros on reset
module pipeStageReg #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clk,
	input  logic     arstN,
	input  payload_t d,
	output payload_t q
);

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			// Zero payload also clears the valid bit
			q <= '0;
		end
		else
		begin
			q <= d;
		end
	end

endmodule

// ==== hdl/memExcChecker.sv ====
`timescale 1ns/1ps

module memExcChecker #(
	parameter int NUM_DEV = 6
) (
	input  memMapPkg::memReq_t      req,
	output mipsIsaPkg::accessKind_t kind,
	output logic                    excGet,
	output mipsIsaPkg::excCode_t    excCode
);
	import mipsIsaPkg::*;
	import memMapPkg::*;

	logic [5:0] opcode;
	logic [1:0] byteSel;
	logic       memAccess;
	logic       misAlign;
	logic       inDm;
	logic       inDev;
	logic       outOfWindow;
	logic       storeNoWrite;
	logic       devNotWord;
	logic       addrErr;

	assign opcode  = req.instr[31:26];
	assign byteSel = req.addr[1:0];

	////////////////////
	// Opcode decode
	////////////////////
	always_comb
	begin
		case (opcode)
			opLB:    kind = '{isLoad: 1'b1, default: 1'b0};
			opLBU:   kind = '{isLoad: 1'b1, loadUnsigned: 1'b1, default: 1'b0};
			opLH:    kind = '{isLoad: 1'b1, halfAlign: 1'b1, default: 1'b0};
			opLHU:   kind = '{isLoad: 1'b1, halfAlign: 1'b1, loadUnsigned: 1'b1, default: 1'b0};
			opLW:    kind = '{isLoad: 1'b1, wordAlign: 1'b1, default: 1'b0};
			opSB:    kind = '{isStore: 1'b1, default: 1'b0};
			opSH:    kind = '{isStore: 1'b1, halfAlign: 1'b1, default: 1'b0};
			opSW:    kind = '{isStore: 1'b1, wordAlign: 1'b1, default: 1'b0};
			default: kind = '0;
		endcase
	end

	assign memAccess = kind.isLoad | kind.isStore;

	////////////////////
	// Window membership
	////////////////////
	assign inDm = (req.addr >= dmMin) && (req.addr <= dmMax);

	// Only the first NUM_DEV windows are populated
	always_comb
	begin
		inDev = 1'b0;
		for (int k = 0; k < NUM_DEV; k++)
		begin
			if (req.addr >= devMin[k] && req.addr <= devMax[k])
				inDev = 1'b1;
		end
	end

	////////////////////
	// Address error conditions, highest priority first
	////////////////////
	assign misAlign     = (kind.halfAlign & byteSel[0]) | (kind.wordAlign & (|byteSel));
	assign outOfWindow  = memAccess & ~(inDm | inDev);
	assign storeNoWrite = kind.isStore & (req.addr == noWriteAddr);
	// Devices take word accesses only
	assign devNotWord   = memAccess & inDev & ~kind.wordAlign;

	// All address errors share one code, so their order only matters for readability
	assign addrErr = misAlign | outOfWindow | storeNoWrite | devNotWord;

	always_comb
	begin
		if (req.preExcGet)
		begin
			// Earlier stage wins and keeps its own code
			excGet  = 1'b1;
			excCode = req.preExcCode;
		end
		else if (addrErr)
		begin
			excGet  = 1'b1;
			excCode = kind.isStore ? excAdES : excAdEL;
		end
		else
		begin
			excGet  = 1'b0;
			excCode = excNone;
		end
	end

	// An upstream stage must never flag an exception with a zero code
	excCodeNonZero: assert final (!(req.valid && excGet) || excCode != excNone)
		else $error("exception flagged with zero code, addr %h", req.addr);

endmodule

// ==== hdl/loadStoreAligner.sv ====
`timescale 1ns/1ps

module loadStoreAligner (
	input  mipsIsaPkg::accessKind_t kind,
	input  logic [1:0]              byteSel,
	input  logic [31:0]             storeData,
	input  logic [31:0]             rawRead,
	output logic [3:0]              byteEn,
	output logic [31:0]             wrData,
	output logic [31:0]             loadData
);

	logic [7:0]  loadByte;
	logic [15:0] loadHalf;

	////////////////////
	// Store lane placement, little endian
	////////////////////
	always_comb
	begin
		byteEn = 4'b0000;
		wrData = storeData;
		if (kind.isStore)
		begin
			if (kind.wordAlign)
			begin
				byteEn = 4'b1111;
			end
			else if (kind.halfAlign)
			begin
				byteEn = byteSel[1] ? 4'b1100 : 4'b0011;
				wrData = {2{storeData[15:0]}};
			end
			else
			begin
				byteEn = 4'b0001 << byteSel;
				wrData = {4{storeData[7:0]}};
			end
		end
	end

	////////////////////
	// Load lane select and extension
	////////////////////
	assign loadByte = rawRead[8*byteSel +: 8];
	assign loadHalf = byteSel[1] ? rawRead[31:16] : rawRead[15:0];

	always_comb
	begin
		if (!kind.isLoad)
			loadData = '0;
		else if (kind.wordAlign)
			loadData = rawRead;
		else if (kind.halfAlign)
			loadData = kind.loadUnsigned ? {16'b0, loadHalf} : {{16{loadHalf[15]}}, loadHalf};
		else
			loadData = kind.loadUnsigned ? {24'b0, loadByte} : {{24{loadByte[7]}}, loadByte};
	end

endmodule

// ==== hdl/dataMemory.sv ====
`timescale 1ns/1ps

module dataMemory (
	input  logic        clk,
	input  logic        arstN,
	input  logic [11:0] wordAddr,
	input  logic        wrEn,
	input  logic [3:0]  byteEn,
	input  logic [31:0] wrData,
	output logic [31:0] rdData
);

	// 0x0000..0x2FFF in words
	localparam int depth = 3072;

	logic [31:0] mem [depth];

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < depth; i++)
				mem[i] <= '0;
		end
		else if (wrEn && wordAddr < depth)
		begin
			for (int b = 0; b < 4; b++)
			begin
				if (byteEn[b])
					mem[wordAddr][8*b +: 8] <= wrData[8*b +: 8];
			end
		end
	end

	// Combinational read, zero above the top word
	assign rdData = (wordAddr < depth) ? mem[wordAddr] : '0;

endmodule

// ==== hdl/deviceBridge.sv ====
`timescale 1ns/1ps

module deviceBridge #(
	parameter int NUM_DEV   = 6,
	parameter int DEV_WORDS = 3
) (
	input  logic        clk,
	input  logic        arstN,
	input  logic [31:0] addr,
	input  logic        wrEn,
	input  logic [31:0] wrData,
	output logic        hit,
	output logic [31:0] rdData
);
	import memMapPkg::*;

	localparam int idxW = $clog2(maxDev);

	logic [idxW-1:0] devIdx;
	logic [1:0]      wordOff;
	logic            wordValid;
	logic [31:0]     bank [NUM_DEV][DEV_WORDS];

	////////////////////
	// Window decode
	////////////////////
	always_comb
	begin
		hit    = 1'b0;
		devIdx = '0;
		for (int k = 0; k < NUM_DEV; k++)
		begin
			if (addr >= devMin[k] && addr <= devMax[k])
			begin
				hit    = 1'b1;
				devIdx = idxW'(k);
			end
		end
	end

	// Windows start on 16-byte boundaries
	assign wordOff   = addr[3:2];
	assign wordValid = (wordOff < DEV_WORDS);

	////////////////////
	// Register banks
	////////////////////
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int d = 0; d < NUM_DEV; d++)
				for (int w = 0; w < DEV_WORDS; w++)
					bank[d][w] <= '0;
		end
		else if (wrEn && hit && wordValid)
		begin
			bank[devIdx][wordOff] <= wrData;
		end
	end

	// Status word is a fixed pattern tagged with the device index
	always_comb
	begin
		rdData = '0;
		if (hit && addr == noWriteAddr)
			rdData = 32'hA500 + devIdx;
		else if (hit && wordValid)
			rdData = bank[devIdx][wordOff];
	end

	// Write strobe from the stage must only land on a decoded window
	wrOnlyOnHit: assert property (@(posedge clk) disable iff (!arstN) wrEn |-> hit)
		else $error("device write outside any window, addr %h", addr);

endmodule

// ==== hdl/memStage.sv ====
`timescale 1ns/1ps

module memStage #(
	parameter int NUM_DEV   = 6,
	parameter int DEV_WORDS = 3
) (
	input  logic                  clk,
	input  logic                  arstN,
	input  memMapPkg::memReq_t    exReq,
	output memMapPkg::memResult_t wbResult
);
	import mipsIsaPkg::*;
	import memMapPkg::*;

	memReq_t     memReq;
	memResult_t  memResult;
	accessKind_t kind;
	logic        excGet;
	excCode_t    excCode;
	logic        inDm;
	logic        storeEn;
	logic        dmWrEn;
	logic        devWrEn;
	logic        devHit;
	logic [31:0] dmRead;
	logic [31:0] devRead;
	logic [31:0] rawRead;
	logic [31:0] wrData;
	logic [31:0] loadData;
	logic [3:0]  byteEn;

	if (NUM_DEV < 1 || NUM_DEV > maxDev)
	begin : badNumDev
		$error("NUM_DEV must be within 1 to %0d", maxDev);
	end

	////////////////////
	// EX/MEM register
	////////////////////
	pipeStageReg #(.payload_t(memReq_t)) exMemReg (
		.clk   (clk),
		.arstN (arstN),
		.d     (exReq),
		.q     (memReq)
	);

	memExcChecker #(.NUM_DEV(NUM_DEV)) checker_i (
		.req     (memReq),
		.kind    (kind),
		.excGet  (excGet),
		.excCode (excCode)
	);

	loadStoreAligner aligner_i (
		.kind      (kind),
		.byteSel   (memReq.addr[1:0]),
		.storeData (memReq.storeData),
		.rawRead   (rawRead),
		.byteEn    (byteEn),
		.wrData    (wrData),
		.loadData  (loadData)
	);

	// Faulting stores never reach memory or devices
	assign inDm    = (memReq.addr >= dmMin) && (memReq.addr <= dmMax);
	assign storeEn = memReq.valid & kind.isStore & ~excGet;
	assign dmWrEn  = storeEn & inDm;
	assign devWrEn = storeEn & devHit;

	dataMemory dataMem_i (
		.clk      (clk),
		.arstN    (arstN),
		.wordAddr (memReq.addr[13:2]),
		.wrEn     (dmWrEn),
		.byteEn   (byteEn),
		.wrData   (wrData),
		.rdData   (dmRead)
	);

	deviceBridge #(.NUM_DEV(NUM_DEV), .DEV_WORDS(DEV_WORDS)) bridge_i (
		.clk    (clk),
		.arstN  (arstN),
		.addr   (memReq.addr),
		.wrEn   (devWrEn),
		.wrData (wrData),
		.hit    (devHit),
		.rdData (devRead)
	);

	assign rawRead = devHit ? devRead : (inDm ? dmRead : '0);

	////////////////////
	// Result packing and MEM/WB register
	////////////////////
	always_comb
	begin
		memResult.valid    = memReq.valid;
		memResult.excGet   = memReq.valid & excGet;
		memResult.excCode  = memResult.excGet ? excCode : excNone;
		// Aligner already zeroes non-loads
		memResult.loadData = (memReq.valid && !excGet) ? loadData : '0;
	end

	pipeStageReg #(.payload_t(memResult_t)) memWbReg (
		.clk   (clk),
		.arstN (arstN),
		.d     (memResult),
		.q     (wbResult)
	);

endmodule

// ==== dv/memStageTb.sv ====
`timescale 1ns/1ps

module memStageTb;
	import mipsIsaPkg::*;
	import memMapPkg::*;

	localparam time clkPeriod  = 20ns;
	localparam time driveDelay = 2ns;

	logic       clk;
	logic       arstN;
	memReq_t    exReq;
	memResult_t wbResult;

	string      names[$];
	memReq_t    reqs[$];
	memResult_t exps[$];
	int         numTests  = 0;
	int         passCount = 0;
	int         failCount = 0;
	int         setupErr  = 0;
	// Mismatches within the test being checked
	int         errCount  = 0;

	memStage dut_i (
		.clk      (clk),
		.arstN    (arstN),
		.exReq    (exReq),
		.wbResult (wbResult)
	);

	always #(clkPeriod / 2) clk = ~clk;

	////////////////////
	// Compare tasks
	////////////////////
	task automatic reportMismatch(input string sig, input logic [31:0] exp, input logic [31:0] act);
		$display("FAILED at %0t: %s expected %h, got %h", $time, sig, exp, act);
		errCount++;
	endtask

	task automatic checkExc(input excCode_t exp, input excCode_t act);
		if (act !== exp)
		begin
			$display("FAILED at %0t: wbResult.excCode expected %0d, got %0d", $time, exp, act);
			errCount++;
		end
	endtask

	task automatic checkResult(input string name, input memResult_t exp, input memResult_t act);
		errCount = 0;
		if (act.valid !== exp.valid)
			reportMismatch("wbResult.valid", exp.valid, act.valid);
		if (act.excGet !== exp.excGet)
			reportMismatch("wbResult.excGet", exp.excGet, act.excGet);
		checkExc(exp.excCode, act.excCode);
		if (act.loadData !== exp.loadData)
			reportMismatch("wbResult.loadData", exp.loadData, act.loadData);
		if (errCount == 0)
		begin
			passCount++;
			$display("%s ok", name);
		end
		else
		begin
			failCount++;
			$display("%s wrong in %0d fields", name, errCount);
		end
	endtask

	////////////////////
	// Test data reader
	////////////////////
	task automatic readTests();
		int          fd;
		string       line;
		string       name;
		logic [31:0] col [8];
		memReq_t     req;
		memResult_t  exp;
		fd = $fopen("dv/memStageTestdata.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the test data file");
			setupErr++;
			return;
		end
		while ($fgets(line, fd) > 0)
		begin
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			if ($sscanf(line, "%s %h %h %h %h %h %h %h %h", name, col[0], col[1], col[2],
				col[3], col[4], col[5], col[6], col[7]) != 9)
			begin
				$display("Malformed test data line: %s", line);
				setupErr++;
				continue;
			end
			req            = '0;
			req.valid      = 1'b1;
			req.instr      = {col[0][5:0], 26'h0};
			req.addr       = col[1];
			req.storeData  = col[2];
			req.preExcGet  = col[3][0];
			req.preExcCode = col[4][4:0];
			// Filler tests carry random store data
			if (name.substr(0, 5) == "filler")
				req.storeData = $urandom;
			exp.valid    = 1'b1;
			exp.excGet   = col[5][0];
			exp.excCode  = col[6][4:0];
			exp.loadData = col[7];
			names.push_back(name);
			reqs.push_back(req);
			exps.push_back(exp);
		end
		$fclose(fd);
		if (reqs.size() == 0)
		begin
			$display("No tests found in the test data file");
			setupErr++;
		end
	endtask

	////////////////////
	// Main sequence
	////////////////////
	initial
	begin
		clk   = 1'b0;
		arstN = 1'b0;
		exReq = '0;
		void'($urandom(6453));
		readTests();
		numTests = reqs.size();
		repeat (3) @(posedge clk);
		#(driveDelay);
		arstN = 1'b1;
		if (wbResult.valid !== 1'b0)
		begin
			$display("wbResult.valid is high right after reset");
			setupErr++;
		end
		// One request per edge, each result checked two edges after it was driven
		for (int i = 0; i < numTests + 2; i++)
		begin
			@(posedge clk);
			#(driveDelay);
			if (i >= 2)
				checkResult(names[i-2], exps[i-2], wbResult);
			exReq = (i < numTests) ? reqs[i] : '0;
		end
		$display("Tests passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0 && setupErr == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Watchdog, three cycles per test plus margin
	initial
	begin
		wait (numTests > 0);
		#((numTests * 3 + 20) * clkPeriod);
		$display("Run timed out before all results were checked");
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== dv/memStageTestdata.txt ====
# name opcode addr storeData preExcGet preExcCode expExcGet expExcCode expLoadData
# all values hex; filler tests get random store data
sw_word       2b 00000100 8123f0a5 0 00 0 00 00000000
lw_word       23 00000100 00000000 0 00 0 00 8123f0a5
lh_low        21 00000100 00000000 0 00 0 00 fffff0a5
lhu_high      25 00000102 00000000 0 00 0 00 00008123
lb_byte0      20 00000100 00000000 0 00 0 00 ffffffa5
lbu_byte1     24 00000101 00000000 0 00 0 00 000000f0
sh_upper      29 00000106 0000beef 0 00 0 00 00000000
sb_byte1      28 00000105 0000007e 0 00 0 00 00000000
lw_merged     23 00000104 00000000 0 00 0 00 beef7e00
lb_signed     20 00000107 00000000 0 00 0 00 ffffffbe
lh_misalign   21 00000101 00000000 0 00 1 04 00000000
lw_misalign   23 00000102 00000000 0 00 1 04 00000000
sh_misalign   29 00000103 00001111 0 00 1 05 00000000
sw_misalign   2b 00000102 22222222 0 00 1 05 00000000
lw_unchanged  23 00000100 00000000 0 00 0 00 8123f0a5
lb_pastDm     20 00003000 00000000 0 00 1 04 00000000
sw_outside    2b 00008000 12345678 0 00 1 05 00000000
lw_devGap     23 00007f0c 00000000 0 00 1 04 00000000
sw_device     2b 00007f14 cafe0001 0 00 0 00 00000000
lw_device     23 00007f14 00000000 0 00 0 00 cafe0001
sb_device     28 00007f20 000000aa 0 00 1 05 00000000
lh_device     21 00007f24 00000000 0 00 1 04 00000000
sw_readOnly   2b 00007f08 ffffffff 0 00 1 05 00000000
lw_readOnly   23 00007f08 00000000 0 00 0 00 0000a500
sw_preExcMis  2b 00000102 33333333 1 0c 1 0c 00000000
sw_preExc     2b 00000104 44444444 1 0c 1 0c 00000000
lw_afterPre   23 00000104 00000000 0 00 0 00 beef7e00
filler_nop    00 00000000 00000000 0 00 0 00 00000000
filler_addi   08 00008000 00000000 0 00 0 00 00000000
filler_ori    0d 00000103 00000000 0 00 0 00 00000000

// ==== memStage.f ====
hdl/mipsIsaPkg.sv
hdl/memMapPkg.sv
hdl/pipeStageReg.sv
hdl/memExcChecker.sv
hdl/loadStoreAligner.sv
hdl/dataMemory.sv
hdl/deviceBridge.sv
hdl/memStage.sv
dv/memStageTb.sv
